//--- design/bus_arbiter.sv
// two-master round-robin arbiter
// address decode onto sram, dma registers and timer
// one-cycle read record that steers rdata and rvalid back

`include "soc_defines.svh"

module bus_arbiter import soc_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	bus_if.arb                 m0,
	bus_if.arb                 m1,
	output logic               sram_sel,
	output logic               dma_sel,
	output logic               tmr_sel,
	output logic               tgt_we,
	output logic [11:0]        tgt_index,
	output logic [`DATA_W-1:0] tgt_wdata,
	input  logic [`DATA_W-1:0] sram_rdata,
	input  logic [`DATA_W-1:0] dma_rdata,
	input  logic [`DATA_W-1:0] tmr_rdata
);

	logic               last_m1;
	logic               pick_m1;
	logic               any_gnt;
	bus_addr_u          win_addr;
	target_e            win_tgt;
	logic               rd_pend;
	logic               rd_m1;
	target_e            rd_tgt;
	logic [`DATA_W-1:0] ret_data;

	// --------------------
	// grant
	// m1 wins when alone, or when m0 won the last turn
	assign pick_m1 = m1.req && (!m0.req || !last_m1);
	assign m1.gnt  = pick_m1;
	assign m0.gnt  = m0.req && !pick_m1;
	assign any_gnt = m0.req || m1.req;

	assign win_addr  = pick_m1 ? m1.addr : m0.addr;
	assign tgt_we    = pick_m1 ? m1.we : m0.we;
	assign tgt_wdata = pick_m1 ? m1.wdata : m0.wdata;

	// --------------------
	// decode
	always_comb begin
		win_tgt = tgt_none;
		if (win_addr.sram.region == REGION_SRAM) begin
			win_tgt = tgt_sram;
		end else if (win_addr.regs.region == REGION_REGS) begin
			if (win_addr.regs.index <= `REG_DMA_CTRL)
				win_tgt = tgt_dma;
			else if (win_addr.regs.index == `REG_TIME || win_addr.regs.index == `REG_TIMECMP)
				win_tgt = tgt_timer;
		end
	end

	// unmapped accesses select nothing
	assign sram_sel = any_gnt && win_tgt == tgt_sram;
	assign dma_sel  = any_gnt && win_tgt == tgt_dma;
	assign tmr_sel  = any_gnt && win_tgt == tgt_timer;

	always_comb begin
		if (win_tgt == tgt_sram)
			tgt_index = win_addr.sram.word;
		else
			tgt_index = {8'd0, win_addr.regs.index};
	end

	// --------------------
	// read return
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_m1 <= 1'b1;
			rd_pend <= 1'b0;
			rd_m1   <= 1'b0;
			rd_tgt  <= tgt_none;
		end else begin
			if (any_gnt)
				last_m1 <= pick_m1;
			rd_pend <= any_gnt && !tgt_we;
			rd_m1   <= pick_m1;
			rd_tgt  <= win_tgt;
		end
	end

	always_comb begin
		case (rd_tgt)
			tgt_sram:  ret_data = sram_rdata;
			tgt_dma:   ret_data = dma_rdata;
			tgt_timer: ret_data = tmr_rdata;
			default:   ret_data = '0;
		endcase
	end

	assign m0.rvalid = rd_pend && !rd_m1;
	assign m1.rvalid = rd_pend && rd_m1;
	assign m0.rdata  = ret_data;
	assign m1.rdata  = ret_data;

	a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		!(m0.gnt && m1.gnt));

	a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
		(!m0.gnt || m0.req) && (!m1.gnt || m1.req));

endmodule

//--- design/bus_if.sv
// request and response bundle of one bus master
// modports for the master side and the arbiter side

`include "soc_defines.svh"

interface bus_if import soc_pkg::*;;

	// request, held until gnt
	logic               req;
	logic               we;
	bus_addr_u          addr;
	logic [`DATA_W-1:0] wdata;

	// grant strobe and read return
	logic               gnt;
	logic               rvalid;
	logic [`DATA_W-1:0] rdata;

	modport master (
		output req, we, addr, wdata,
		input  gnt, rvalid, rdata
	);

	modport arb (
		input  req, we, addr, wdata,
		output gnt, rvalid, rdata
	);

endinterface

//--- design/dma_copy.sv
// dma register block: src, dst, len, ctrl
// word-by-word copy engine mastering the shared bus
// irq follows the done flag

`include "soc_defines.svh"

module dma_copy import soc_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               reg_sel,
	input  logic               reg_we,
	input  logic [3:0]         reg_index,
	input  logic [`DATA_W-1:0] reg_wdata,
	output logic [`DATA_W-1:0] reg_rdata,
	output logic               irq,
	bus_if.master              bus
);

	localparam int PTR_W = `ADDR_W - 4;
	localparam int LEN_W = $clog2(`SRAM_WORDS) + 1;

	localparam logic [1:0] S_IDLE    = 2'd0;
	localparam logic [1:0] S_RD_REQ  = 2'd1;
	localparam logic [1:0] S_RD_WAIT = 2'd2;
	localparam logic [1:0] S_WR_REQ  = 2'd3;

	logic [1:0]         state;
	logic [PTR_W-1:0]   src_reg;
	logic [PTR_W-1:0]   dst_reg;
	logic [LEN_W-1:0]   len_reg;
	logic [PTR_W-1:0]   src_ptr;
	logic [PTR_W-1:0]   dst_ptr;
	logic [LEN_W-1:0]   remain;
	logic [`DATA_W-1:0] data_buf;
	logic               done;
	logic               busy;
	logic               ctrl_wr;
	logic               start;

	assign busy    = state != S_IDLE;
	assign ctrl_wr = reg_sel && reg_we && reg_index == `REG_DMA_CTRL;
	// start while busy is dropped
	assign start   = ctrl_wr && reg_wdata[0] && !busy;
	assign irq     = done;

	// --------------------
	// registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_reg <= '0;
			dst_reg <= '0;
			len_reg <= '0;
		end else if (reg_sel && reg_we) begin
			case (reg_index)
				`REG_DMA_SRC: src_reg <= reg_wdata[PTR_W-1:0];
				`REG_DMA_DST: dst_reg <= reg_wdata[PTR_W-1:0];
				`REG_DMA_LEN: len_reg <= reg_wdata[LEN_W-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reg_sel && !reg_we) begin
			case (reg_index)
				`REG_DMA_SRC:  reg_rdata <= {{(`DATA_W-PTR_W){1'b0}}, src_reg};
				`REG_DMA_DST:  reg_rdata <= {{(`DATA_W-PTR_W){1'b0}}, dst_reg};
				`REG_DMA_LEN:  reg_rdata <= {{(`DATA_W-LEN_W){1'b0}}, len_reg};
				`REG_DMA_CTRL: reg_rdata <= {{(`DATA_W-2){1'b0}}, done, busy};
				default:       reg_rdata <= '0;
			endcase
		end
	end

	// --------------------
	// copy fsm
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			src_ptr <= '0;
			dst_ptr <= '0;
			remain  <= '0;
			done    <= 1'b0;
		end else begin
			if (ctrl_wr)
				done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						src_ptr <= src_reg;
						dst_ptr <= dst_reg;
						remain  <= len_reg;
						// zero length finishes at once
						if (len_reg == '0)
							done <= 1'b1;
						else
							state <= S_RD_REQ;
					end
				end
				S_RD_REQ: begin
					if (bus.gnt)
						state <= S_RD_WAIT;
				end
				S_RD_WAIT: begin
					if (bus.rvalid)
						state <= S_WR_REQ;
				end
				default: begin
					if (bus.gnt) begin
						src_ptr <= src_ptr + 1'b1;
						dst_ptr <= dst_ptr + 1'b1;
						remain  <= remain - 1'b1;
						if (remain == LEN_W'(1)) begin
							state <= S_IDLE;
							done  <= 1'b1;
						end else begin
							state <= S_RD_REQ;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_RD_WAIT && bus.rvalid)
			data_buf <= bus.rdata;
	end

	// --------------------
	// bus request
	always_comb begin
		bus.req              = state == S_RD_REQ || state == S_WR_REQ;
		bus.we               = state == S_WR_REQ;
		bus.wdata            = data_buf;
		bus.addr             = '0;
		bus.addr.sram.region = REGION_SRAM;
		bus.addr.sram.word   = (state == S_WR_REQ) ? dst_ptr : src_ptr;
	end

	a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
		!busy |-> !bus.req);

	// the fsm waits on rvalid, so it must follow every read grant
	a_rd_return: assert property (@(posedge clk) disable iff (!rst_n)
		state == S_RD_REQ && bus.gnt |=> bus.rvalid);

endmodule

//--- design/soc_defines.svh
// shared widths, sram depth and timebase
// register word indices of the dma and timer blocks

`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// bus widths
`define ADDR_W 16
`define DATA_W 32

// word sram depth
`define SRAM_WORDS 256

// clock cycles per microsecond
`define CLK_MHZ 10

// register word indices in the register region
`define REG_DMA_SRC  4'd0
`define REG_DMA_DST  4'd1
`define REG_DMA_LEN  4'd2
`define REG_DMA_CTRL 4'd3
`define REG_TIME     4'd4
`define REG_TIMECMP  4'd5

`endif

//--- design/soc_pkg.sv
// bus address union with its sram and register views
// region codes and the decoded target enum

`include "soc_defines.svh"

package soc_pkg;

	// top two address bits pick the region
	localparam logic [1:0] REGION_SRAM = 2'd0;
	localparam logic [1:0] REGION_REGS = 2'd1;

	// one byte address seen two ways
	typedef union packed {
		struct packed {
			logic [1:0]          region;
			logic [`ADDR_W-5:0]  word;
			logic [1:0]          byte_off;
		} sram;
		struct packed {
			logic [1:0]          region;
			logic [`ADDR_W-7:0]  rsvd;
			logic [3:0]          index;
		} regs;
	} bus_addr_u;

	// where the granted access goes
	typedef enum logic [1:0] {
		tgt_sram,
		tgt_dma,
		tgt_timer,
		tgt_none
	} target_e;

endpackage

//--- design/soc_top.sv
// top level of the shared-memory system
// host port and dma engine share one bus through the arbiter
// targets: word sram, dma registers, microsecond timer

`include "soc_defines.svh"

module soc_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               host_req,
	input  logic               host_we,
	input  logic [`ADDR_W-1:0] host_addr,
	input  logic [`DATA_W-1:0] host_wdata,
	output logic               host_gnt,
	output logic               host_rvalid,
	output logic [`DATA_W-1:0] host_rdata,
	output logic               dma_irq,
	output logic               timer_irq
);

	logic               sram_sel;
	logic               dma_sel;
	logic               tmr_sel;
	logic               tgt_we;
	logic [11:0]        tgt_index;
	logic [`DATA_W-1:0] tgt_wdata;
	logic [`DATA_W-1:0] sram_rdata;
	logic [`DATA_W-1:0] dma_rdata;
	logic [`DATA_W-1:0] tmr_rdata;

	bus_if host_bus ();
	bus_if dma_bus ();

	// --------------------
	// host port
	assign host_bus.req   = host_req;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_gnt       = host_bus.gnt;
	assign host_rvalid    = host_bus.rvalid;
	assign host_rdata     = host_bus.rdata;

	// --------------------
	// fabric and targets
	// host on m0, dma on m1
	bus_arbiter u_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.m0         (host_bus.arb),
		.m1         (dma_bus.arb),
		.sram_sel   (sram_sel),
		.dma_sel    (dma_sel),
		.tmr_sel    (tmr_sel),
		.tgt_we     (tgt_we),
		.tgt_index  (tgt_index),
		.tgt_wdata  (tgt_wdata),
		.sram_rdata (sram_rdata),
		.dma_rdata  (dma_rdata),
		.tmr_rdata  (tmr_rdata)
	);

	sram_store u_sram (
		.clk   (clk),
		.sel   (sram_sel),
		.we    (tgt_we),
		.index (tgt_index),
		.wdata (tgt_wdata),
		.rdata (sram_rdata)
	);

	dma_copy u_dma (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_sel   (dma_sel),
		.reg_we    (tgt_we),
		.reg_index (tgt_index[3:0]),
		.reg_wdata (tgt_wdata),
		.reg_rdata (dma_rdata),
		.irq       (dma_irq),
		.bus       (dma_bus.master)
	);

	us_timer u_timer (
		.clk   (clk),
		.rst_n (rst_n),
		.sel   (tmr_sel),
		.we    (tgt_we),
		.index (tgt_index[3:0]),
		.wdata (tgt_wdata),
		.rdata (tmr_rdata),
		.irq   (timer_irq)
	);

endmodule

//--- design/sram_store.sv
// synchronous word sram
// write on select with we, registered read data

`include "soc_defines.svh"

module sram_store (
	input  logic               clk,
	input  logic               sel,
	input  logic               we,
	input  logic [11:0]        index,
	input  logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata
);

	localparam int AW = $clog2(`SRAM_WORDS);

	logic [`DATA_W-1:0] mem [`SRAM_WORDS];
	logic [AW-1:0]      word_addr;

	// upper index bits are dropped, so words alias modulo the depth
	assign word_addr = index[AW-1:0];

	always_ff @(posedge clk) begin
		if (sel) begin
			if (we)
				mem[word_addr] <= wdata;
			else
				rdata <= mem[word_addr];
		end
	end

	a_index_range: assert property (@(posedge clk)
		sel |-> index < `SRAM_WORDS)
	else
		$warning("sram index %0d aliases onto word %0d", index, word_addr);

endmodule

//--- design/us_timer.sv
// microsecond prescaler and 32-bit time counter
// writable time and timecmp registers
// level irq while time >= timecmp

`include "soc_defines.svh"

module us_timer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sel,
	input  logic               we,
	input  logic [3:0]         index,
	input  logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdata,
	output logic               irq
);

	localparam int PRE_W = $clog2(`CLK_MHZ);

	logic [PRE_W-1:0]   pre_cnt;
	logic               tick;
	logic [`DATA_W-1:0] mtime;
	logic [`DATA_W-1:0] mtimecmp;

	// one tick every CLK_MHZ cycles
	assign tick = pre_cnt == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pre_cnt <= PRE_W'(`CLK_MHZ - 1);
		else if (tick)
			pre_cnt <= PRE_W'(`CLK_MHZ - 1);
		else
			pre_cnt <= pre_cnt - 1'b1;
	end

	// a write to time wins over the tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime    <= '0;
			mtimecmp <= '1;
			irq      <= 1'b0;
		end else begin
			if (sel && we && index == `REG_TIME)
				mtime <= wdata;
			else if (tick)
				mtime <= mtime + 1'b1;
			if (sel && we && index == `REG_TIMECMP)
				mtimecmp <= wdata;
			irq <= mtime >= mtimecmp;
		end
	end

	always_ff @(posedge clk) begin
		if (sel && !we) begin
			case (index)
				`REG_TIME:    rdata <= mtime;
				`REG_TIMECMP: rdata <= mtimecmp;
				default:      rdata <= '0;
			endcase
		end
	end

endmodule

//--- project.f
+incdir+design
design/soc_pkg.sv
design/bus_if.sv
design/bus_arbiter.sv
design/sram_store.sv
design/dma_copy.sv
design/us_timer.sv
design/soc_top.sv
verif/soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build soc_tb with verilator, run it, and decide from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module soc_tb -f project.f -o soc_sim \
	> sim.log 2>&1 && ./obj_dir/soc_sim >> sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1

//--- verif/soc_tb.sv
// testbench of the shared-memory system
// clock, reset, host bus tasks, value check and cycle timeout
// directed tests: reset state, sram, unmapped space, dma copy, timer

`include "soc_defines.svh"

module soc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// the five tests take a few hundred cycles, so this leaves a wide margin
	localparam int MAX_CYCLES = 20000;

	logic        clk;
	logic        rst_n;
	logic        host_req;
	logic        host_we;
	logic [15:0] host_addr;
	logic [31:0] host_wdata;
	logic        host_gnt;
	logic        host_rvalid;
	logic [31:0] host_rdata;
	logic        dma_irq;
	logic        timer_irq;

	logic [31:0] sram_model [256];
	integer      seed;
	int          cycle_cnt = 0;

	soc_top u_soc_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.host_req    (host_req),
		.host_we     (host_we),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_gnt    (host_gnt),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.dma_irq     (dma_irq),
		.timer_irq   (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$fatal(1);
		end
	end

	// --------------------
	// helpers
	task automatic check_eq(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	function automatic logic [15:0] sram_addr(input logic [11:0] word);
		return {2'b00, word, 2'b00};
	endfunction

	function automatic logic [15:0] reg_addr(input logic [3:0] index);
		return {2'b01, 10'd0, index};
	endfunction

	// called and left 1 ns after a rising edge
	task automatic bus_request(input logic we, input logic [15:0] addr,
		input logic [31:0] wdata);
		host_req   = 1'b1;
		host_we    = we;
		host_addr  = addr;
		host_wdata = wdata;
		@(negedge clk);
		while (!host_gnt) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
	endtask

	task automatic host_write(input logic [15:0] addr, input logic [31:0] wdata);
		bus_request(1'b1, addr, wdata);
	endtask

	// read data must come back in the cycle after the grant
	task automatic host_read(input logic [15:0] addr, output logic [31:0] rdata);
		int waited;
		bus_request(1'b0, addr, 32'd0);
		waited = 0;
		@(negedge clk);
		while (!host_rvalid) begin
			waited++;
			@(negedge clk);
		end
		check_eq("host_read latency", 32'd0, 32'(waited));
		rdata = host_rdata;
		@(posedge clk);
		#1;
	endtask

	// --------------------
	// tests
	task automatic test_reset();
		@(negedge clk);
		check_eq("reset host_gnt", 32'd0, 32'(host_gnt));
		check_eq("reset host_rvalid", 32'd0, 32'(host_rvalid));
		check_eq("reset dma_irq", 32'd0, 32'(dma_irq));
		check_eq("reset timer_irq", 32'd0, 32'(timer_irq));
		@(posedge clk);
		#1;
	endtask

	task automatic test_sram();
		logic [11:0] idx_list [16];
		logic [31:0] rnd;
		logic [31:0] data;
		logic [31:0] rdata;
		for (int i = 0; i < 16; i++) begin
			rnd = $random(seed);
			idx_list[i] = rnd[11:0];
			data = $random(seed);
			host_write(sram_addr(idx_list[i]), data);
			sram_model[idx_list[i][7:0]] = data;
		end
		for (int i = 0; i < 16; i++) begin
			host_read(sram_addr(idx_list[i]), rdata);
			check_eq("sram readback", sram_model[idx_list[i][7:0]], rdata);
			// other upper index bits reach the same word
			host_read(sram_addr(idx_list[i] ^ 12'h500), rdata);
			check_eq("sram alias", sram_model[idx_list[i][7:0]], rdata);
		end
	endtask

	task automatic test_unmapped();
		logic [31:0] data;
		logic [31:0] rdata;
		data = $random(seed);
		host_write(sram_addr(12'h010), data);
		sram_model[8'h10] = data;
		host_read({2'b10, 12'h010, 2'b00}, rdata);
		check_eq("unmapped region read", 32'd0, rdata);
		host_read(reg_addr(4'd9), rdata);
		check_eq("unmapped register read", 32'd0, rdata);
		host_write({2'b10, 12'h010, 2'b00}, ~data);
		host_write({2'b11, 12'h010, 2'b00}, ~data);
		host_write(reg_addr(4'd9), ~data);
		host_read(sram_addr(12'h010), rdata);
		check_eq("unmapped write", sram_model[8'h10], rdata);
	endtask

	task automatic test_dma();
		logic [31:0] data;
		logic [31:0] rdata;
		int          polls;
		for (int i = 0; i < 8; i++) begin
			data = $random(seed);
			host_write(sram_addr(12'(16 + i)), data);
			sram_model[16 + i] = data;
		end
		data = $random(seed);
		host_write(sram_addr(12'd200), data);
		sram_model[200] = data;

		host_write(reg_addr(`REG_DMA_SRC), 32'd16);
		host_write(reg_addr(`REG_DMA_DST), 32'd64);
		host_write(reg_addr(`REG_DMA_LEN), 32'd8);
		host_write(reg_addr(`REG_DMA_CTRL), 32'd1);

		// host traffic competes with the copy
		polls = 0;
		while (!dma_irq) begin
			host_read(sram_addr(12'd200), rdata);
			check_eq("dma contention read", sram_model[200], rdata);
			polls++;
		end
		check_eq("dma reads during copy", 32'd1, 32'(polls > 0));

		for (int i = 0; i < 8; i++) begin
			sram_model[64 + i] = sram_model[16 + i];
			host_read(sram_addr(12'(64 + i)), rdata);
			check_eq("dma destination", sram_model[64 + i], rdata);
		end
		host_read(reg_addr(`REG_DMA_CTRL), rdata);
		check_eq("dma ctrl done", 32'h2, rdata);

		host_write(reg_addr(`REG_DMA_CTRL), 32'd0);
		check_eq("dma irq clear", 32'd0, 32'(dma_irq));
		host_read(reg_addr(`REG_DMA_CTRL), rdata);
		check_eq("dma ctrl idle", 32'h0, rdata);
	endtask

	task automatic test_timer();
		logic [31:0] t0;
		logic [31:0] t1;
		logic [31:0] rdata;
		int          waited;
		host_read(reg_addr(`REG_TIME), t0);
		repeat (5 * `CLK_MHZ) @(posedge clk);
		#1;
		host_read(reg_addr(`REG_TIME), t1);
		check_eq("timer advances", 32'd1, 32'(t1 > t0));

		check_eq("timer irq idle", 32'd0, 32'(timer_irq));
		host_read(reg_addr(`REG_TIME), t1);
		host_write(reg_addr(`REG_TIMECMP), t1 + 32'd3);
		waited = 0;
		while (!timer_irq) begin
			if (waited >= 5 * `CLK_MHZ)
				report_failure("timer_irq did not rise within five microseconds");
			@(negedge clk);
			waited++;
		end
		// level stays while time is past timecmp
		for (int i = 0; i < 2 * `CLK_MHZ; i++) begin
			@(negedge clk);
			check_eq("timer irq holds", 32'd1, 32'(timer_irq));
		end
		@(posedge clk);
		#1;

		host_write(reg_addr(`REG_TIMECMP), 32'hffff_ffff);
		@(posedge clk);
		#1;
		check_eq("timer irq clear", 32'd0, 32'(timer_irq));
		host_read(reg_addr(`REG_TIMECMP), rdata);
		check_eq("timecmp readback", 32'hffff_ffff, rdata);
	endtask

	// --------------------
	// sequence
	initial begin
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		rst_n      = 1'b0;
		seed       = 32'h4e7df0cf;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset();
		test_sram();
		test_unmapped();
		test_dma();
		test_timer();

		$display("** PASS **");
		$finish;
	end

endmodule
